// File: source/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // Bus and line geometry.
    localparam int ADDR_WIDTH       = 32;   // Byte address.
    localparam int LINE_WIDTH       = 128;
    localparam int LINE_OFFSET_BITS = 4;    // 16 bytes per line.

    // Data addresses whose top nibble matches REMAP_NIBBLE are line-aligned
    // and moved up by REMAP_OFFSET before they reach the memory.
    localparam logic [3:0]            REMAP_NIBBLE = 4'h0;
    localparam logic [ADDR_WIDTH-1:0] REMAP_OFFSET = 32'h0000_0800;

    // Depth of the line memory unless the top level overrides it.
    localparam int MEM_LINES_DEFAULT = 256;

endpackage

// File: source/bus_pkg.sv
package bus_pkg;

    // Owner of the memory response in the current cycle.
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        I_CACHE = 2'd1,
        MEM     = 2'd2
    } grant_e;

    // Kind of a data-side request.
    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } bus_cmd_e;

endpackage

// File: source/mem_port_if.sv
`timescale 1ns/1ns

interface mem_port_if;

    logic [mem_cfg_pkg::ADDR_WIDTH-1:0] addr;
    logic                               cs;     // Held while a request is outstanding.
    logic                               we;
    logic [mem_cfg_pkg::LINE_WIDTH-1:0] wdata;
    logic [mem_cfg_pkg::LINE_WIDTH-1:0] rdata;
    logic                               rvalid; // One-cycle completion pulse.

    modport requester (
        output addr,
        output cs,
        output we,
        output wdata,
        input  rdata,
        input  rvalid
    );

    modport memory (
        input  addr,
        input  cs,
        input  we,
        input  wdata,
        output rdata,
        output rvalid
    );

endinterface

// File: source/ifetch_port.sv
`timescale 1ns/1ns

module ifetch_port (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               req_i,
    input  logic [mem_cfg_pkg::ADDR_WIDTH-1:0] addr_i,
    output logic [mem_cfg_pkg::LINE_WIDTH-1:0] rdata_o,
    output logic                               done_o,
    output logic                               stall_o,
    mem_port_if.requester                      bus
);

    logic                               busy_q;
    logic [mem_cfg_pkg::ADDR_WIDTH-1:0] addr_q;
    logic [mem_cfg_pkg::LINE_WIDTH-1:0] line_q;
    logic                               accept;

    // A new fetch is taken only when nothing is outstanding.
    assign accept = req_i && !busy_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (busy_q && bus.rvalid) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= addr_i;
        end
        if (done_o) begin
            line_q <= bus.rdata;   // Last fetched line stays on rdata_o.
        end
    end

    assign bus.cs    = busy_q;
    assign bus.addr  = addr_q;
    assign bus.we    = 1'b0;       // Fetches never write.
    assign bus.wdata = '0;

    assign done_o  = busy_q && bus.rvalid;
    assign rdata_o = done_o ? bus.rdata : line_q;
    assign stall_o = busy_q;

    // A returned line always answers the fetch that is still outstanding.
    property p_rvalid_only_when_fetching;
        @(posedge clk_i) disable iff (!rst_ni)
            bus.rvalid |-> bus.cs;
    endproperty

    a_rvalid_only_when_fetching : assert property (p_rvalid_only_when_fetching)
        else $error("ifetch_port: rvalid arrived without an outstanding fetch.");

endmodule

// File: source/dmem_port.sv
`timescale 1ns/1ns

module dmem_port (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               req_i,
    input  logic                               we_i,
    input  logic [mem_cfg_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [mem_cfg_pkg::LINE_WIDTH-1:0] wdata_i,
    output logic [mem_cfg_pkg::LINE_WIDTH-1:0] rdata_o,
    output logic                               done_o,
    mem_port_if.requester                      bus
);

    logic                               busy_q;
    bus_pkg::bus_cmd_e                  cmd_q;
    bus_pkg::bus_cmd_e                  req_cmd;
    logic [mem_cfg_pkg::ADDR_WIDTH-1:0] addr_q;
    logic [mem_cfg_pkg::LINE_WIDTH-1:0] wdata_q;
    logic [mem_cfg_pkg::LINE_WIDTH-1:0] line_q;
    logic                               accept;
    logic                               read_done;

    assign req_cmd = we_i ? bus_pkg::CMD_WRITE : bus_pkg::CMD_READ;
    assign accept  = req_i && !busy_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            cmd_q  <= bus_pkg::CMD_READ;
        end else if (accept) begin
            busy_q <= 1'b1;
            cmd_q  <= req_cmd;
        end else if (done_o) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        if (read_done) begin
            line_q <= bus.rdata;
        end
    end

    assign bus.cs    = busy_q;
    assign bus.we    = busy_q && (cmd_q == bus_pkg::CMD_WRITE);
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    // The arbiter answers a write with its own rvalid pulse, so one strobe ends both kinds.
    assign done_o    = busy_q && bus.rvalid;
    assign read_done = done_o && (cmd_q == bus_pkg::CMD_READ);
    assign rdata_o   = read_done ? bus.rdata : line_q;

    property p_no_req_while_busy;
        @(posedge clk_i) disable iff (!rst_ni)
            busy_q |-> !req_i;
    endproperty

    a_no_req_while_busy : assert property (p_no_req_while_busy)
        else $error("dmem_port: request while a transaction is outstanding.");

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       i_stall_i,
    mem_port_if.memory    i_bus,
    mem_port_if.memory    d_bus,
    mem_port_if.requester m_bus
);

    bus_pkg::grant_e   state_q;
    bus_pkg::grant_e   state_d;
    bus_pkg::bus_cmd_e d_cmd;

    logic i_go;       // Instruction read issued this cycle.
    logic d_wr_go;    // Data write forwarded this cycle.
    logic d_rd_go;    // Data read issued this cycle.
    logic d_rd_done;
    logic wr_ack_q;

    logic                               hold_valid_q;
    logic [mem_cfg_pkg::LINE_WIDTH-1:0] hold_data_q;

    logic                               d_low;
    logic [mem_cfg_pkg::ADDR_WIDTH-1:0] d_line_addr;
    logic [mem_cfg_pkg::ADDR_WIDTH-1:0] d_addr_eff;

    assign d_cmd = d_bus.we ? bus_pkg::CMD_WRITE : bus_pkg::CMD_READ;

    // Instruction side always wins. The fetch being answered is not reissued.
    assign i_go    = i_bus.cs && (state_q != bus_pkg::I_CACHE);
    assign d_wr_go = d_bus.cs && (d_cmd == bus_pkg::CMD_WRITE) && !i_bus.cs && !wr_ack_q;
    assign d_rd_go = d_bus.cs && (d_cmd == bus_pkg::CMD_READ) && !i_bus.cs
                     && !i_stall_i && (state_q == bus_pkg::IDLE);

    // Held data goes out only once the instruction side has stopped stalling.
    assign d_rd_done = (state_q == bus_pkg::MEM) && hold_valid_q && !i_stall_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            bus_pkg::IDLE: begin
                if (i_go) begin
                    state_d = bus_pkg::I_CACHE;
                end else if (d_rd_go) begin
                    state_d = bus_pkg::MEM;
                end
            end
            bus_pkg::I_CACHE: begin
                // A data line parked during the fetch is delivered next.
                if (m_bus.rvalid) begin
                    state_d = hold_valid_q ? bus_pkg::MEM : bus_pkg::IDLE;
                end
            end
            bus_pkg::MEM: begin
                if (i_go) begin
                    state_d = bus_pkg::I_CACHE;
                end else if (d_rd_done) begin
                    state_d = bus_pkg::IDLE;
                end
            end
            default: state_d = bus_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q  <= bus_pkg::IDLE;
            wr_ack_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            wr_ack_q <= d_wr_go;
        end
    end

    // Data read holding register.
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            hold_valid_q <= 1'b0;
            hold_data_q  <= '0;
        end else if (!(i_stall_i && hold_valid_q)) begin
            hold_valid_q <= m_bus.rvalid && (state_q == bus_pkg::MEM);
            hold_data_q  <= m_bus.rdata;
        end
    end

    // Low-region remap of data addresses.
    assign d_low = d_bus.addr[mem_cfg_pkg::ADDR_WIDTH-1 -: 4] == mem_cfg_pkg::REMAP_NIBBLE;
    assign d_line_addr = {d_bus.addr[mem_cfg_pkg::ADDR_WIDTH-1:mem_cfg_pkg::LINE_OFFSET_BITS],
                          {mem_cfg_pkg::LINE_OFFSET_BITS{1'b0}}};
    assign d_addr_eff = d_low ? d_line_addr + mem_cfg_pkg::REMAP_OFFSET : d_bus.addr;

    assign m_bus.cs    = i_go || d_wr_go || d_rd_go;
    assign m_bus.addr  = i_bus.cs ? i_bus.addr : d_addr_eff;
    assign m_bus.we    = d_wr_go;
    assign m_bus.wdata = d_bus.wdata;

    assign i_bus.rvalid = (state_q == bus_pkg::I_CACHE) && m_bus.rvalid;
    assign i_bus.rdata  = m_bus.rdata;     // passthrough

    assign d_bus.rvalid = wr_ack_q || d_rd_done;
    assign d_bus.rdata  = hold_data_q;

    a_grant_has_fetch : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == bus_pkg::I_CACHE) |-> i_bus.cs)
        else $error("mem_arbiter: fetch grant without a pending fetch.");

    a_no_write_during_fetch : assert property (@(posedge clk_i) disable iff (!rst_ni)
        m_bus.we |-> !i_stall_i)
        else $error("mem_arbiter: memory write while the instruction side stalls.");

endmodule

// File: source/line_memory.sv
`timescale 1ns/1ns

module line_memory #(
    parameter int MEM_LINES = mem_cfg_pkg::MEM_LINES_DEFAULT
) (
    input logic        clk_i,
    mem_port_if.memory bus
);

    localparam int INDEX_BITS = $clog2(MEM_LINES);

    logic [mem_cfg_pkg::LINE_WIDTH-1:0] mem_q [MEM_LINES];
    logic [INDEX_BITS-1:0]              index;
    logic [mem_cfg_pkg::LINE_WIDTH-1:0] rdata_q;
    logic                               rvalid_q;
    logic                               rd_en;
    logic                               wr_en;

    // Line index wraps modulo the memory depth.
    assign index = bus.addr[mem_cfg_pkg::LINE_OFFSET_BITS +: INDEX_BITS];
    assign rd_en = bus.cs && !bus.we;
    assign wr_en = bus.cs && bus.we;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[index] <= bus.wdata;
        end
    end

    // One cycle of read latency.
    always_ff @(posedge clk_i) begin
        rvalid_q <= rd_en;
        if (rd_en) begin
            rdata_q <= mem_q[index];
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

endmodule

// File: source/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top #(
    parameter int MEM_LINES = mem_cfg_pkg::MEM_LINES_DEFAULT
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    // Instruction port.
    input  logic                               i_req_i,
    input  logic [mem_cfg_pkg::ADDR_WIDTH-1:0] i_addr_i,
    output logic [mem_cfg_pkg::LINE_WIDTH-1:0] i_rdata_o,
    output logic                               i_done_o,
    // Data port.
    input  logic                               d_req_i,
    input  logic                               d_we_i,
    input  logic [mem_cfg_pkg::ADDR_WIDTH-1:0] d_addr_i,
    input  logic [mem_cfg_pkg::LINE_WIDTH-1:0] d_wdata_i,
    output logic [mem_cfg_pkg::LINE_WIDTH-1:0] d_rdata_o,
    output logic                               d_done_o
);

    mem_port_if i_bus ();
    mem_port_if d_bus ();
    mem_port_if m_bus ();

    logic i_stall;   // High while a fetch is outstanding.

    ifetch_port u_ifetch (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (i_req_i),
        .addr_i  (i_addr_i),
        .rdata_o (i_rdata_o),
        .done_o  (i_done_o),
        .stall_o (i_stall),
        .bus     (i_bus.requester)
    );

    dmem_port u_dmem (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (d_req_i),
        .we_i    (d_we_i),
        .addr_i  (d_addr_i),
        .wdata_i (d_wdata_i),
        .rdata_o (d_rdata_o),
        .done_o  (d_done_o),
        .bus     (d_bus.requester)
    );

    mem_arbiter u_arbiter (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .i_stall_i (i_stall),
        .i_bus     (i_bus.memory),
        .d_bus     (d_bus.memory),
        .m_bus     (m_bus.requester)
    );

    line_memory #(
        .MEM_LINES (MEM_LINES)
    ) u_memory (
        .clk_i (clk_i),
        .bus   (m_bus.memory)
    );

endmodule

// File: verif/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Low-region data addresses are line-aligned and moved up by 0x800.
function automatic logic [31:0] effective_addr(input logic [31:0] addr);
    return (addr[31:28] == 4'h0) ? {addr[31:4], 4'h0} + 32'h800 : addr;
endfunction

// One line per index, wrapping modulo the memory depth.
function automatic int line_key(input logic [31:0] addr);
    return int'((addr >> 4) % MEM_LINES);
endfunction

function automatic logic [127:0] random_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
endfunction

task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
        errors++;
        $display("FAIL %0t: %s", $time, what);
    end
endtask

task automatic compare_line(input logic [127:0] got, input logic [127:0] exp, input string what);
    expect_true(got === exp, $sformatf("%s returned %h, expected %h", what, got, exp));
endtask

// Outputs are sampled on the falling edge, well clear of the input changes.
task automatic wait_done(input bit instr, output logic [127:0] line, output int at_cycle);
    int n;
    n = 0;
    line = '0;
    at_cycle = -1;
    while (n < WAIT_LIMIT && at_cycle < 0) begin
        @(negedge clk_i);
        if (instr ? i_done_o : d_done_o) begin
            line = instr ? i_rdata_o : d_rdata_o;
            at_cycle = cycle_cnt;
        end
        n++;
    end
    if (at_cycle < 0) begin
        errors++;
        $display("Timed out after %0d cycles waiting for a done strobe.", WAIT_LIMIT);
    end
endtask

// One-cycle request pulses, driven just after the rising edge.
task automatic pulse_requests(input bit fetch, input bit data, input bit we,
                              input logic [31:0] f_addr, input logic [31:0] d_addr,
                              input logic [127:0] wline, output int start);
    @(posedge clk_i);
    #1;
    start     = cycle_cnt;
    i_req_i   = fetch;
    i_addr_i  = f_addr;
    d_req_i   = data;
    d_we_i    = we;
    d_addr_i  = d_addr;
    d_wdata_i = wline;
    @(posedge clk_i);
    #1;
    i_req_i = 1'b0;
    d_req_i = 1'b0;
endtask

task automatic data_access(input bit we, input logic [31:0] addr, input logic [127:0] wline);
    logic [127:0] got;
    int start;
    int at;
    pulse_requests(1'b0, 1'b1, we, '0, addr, wline, start);
    wait_done(1'b0, got, at);
    if (we) begin
        model_mem[line_key(effective_addr(addr))] = wline;
    end else begin
        compare_line(got, model_mem[line_key(effective_addr(addr))],
                     $sformatf("data read of %h", addr));
    end
endtask

// Fetch addresses reach the memory unchanged.
task automatic fetch_check(input logic [31:0] addr, output int latency);
    logic [127:0] got;
    int start;
    int at;
    pulse_requests(1'b1, 1'b0, 1'b0, addr, '0, '0, start);
    wait_done(1'b1, got, at);
    latency = at - start;
    compare_line(got, model_mem[line_key(addr)], $sformatf("fetch of %h", addr));
endtask

task automatic test_idle_after_reset();
    repeat (10) begin
        @(negedge clk_i);
        expect_true(!i_done_o && !d_done_o, "done strobe seen without any request");
    end
endtask

task automatic test_data_write_read();
    data_access(1'b1, 32'h4000_0120, random_line());
    data_access(1'b0, 32'h4000_0120, '0);
endtask

task automatic test_low_region_remap();
    int lat;
    data_access(1'b1, 32'h0000_0010, random_line());
    fetch_check(32'h0000_0810, lat);   // Same line as data address 0x10.
    data_access(1'b1, 32'h5000_0040, random_line());
    fetch_check(32'h5000_0040, lat);
endtask

task automatic test_fetch_latency();
    int lat;
    data_access(1'b1, 32'h7000_0300, random_line());
    fetch_check(32'h7000_0300, lat);
    expect_true(lat == 2, $sformatf("fetch took %0d cycles instead of 2", lat));
endtask

task automatic test_simultaneous();
    logic [127:0] i_line;
    logic [127:0] d_line;
    int start;
    int i_at;
    int d_at;
    data_access(1'b1, 32'h6000_0200, random_line());
    data_access(1'b1, 32'h3000_0080, random_line());
    pulse_requests(1'b1, 1'b1, 1'b0, 32'h3000_0080, 32'h6000_0200, '0, start);
    fork
        wait_done(1'b1, i_line, i_at);
        wait_done(1'b0, d_line, d_at);
    join
    expect_true(i_at >= 0 && i_at <= d_at, "fetch did not finish before the data read");
    compare_line(i_line, model_mem[line_key(32'h3000_0080)], "concurrent fetch");
    compare_line(d_line, model_mem[line_key(effective_addr(32'h6000_0200))],
                 "concurrent data read");
endtask

// Reads only touch lines written earlier in the run.
task automatic test_random_mix();
    logic [31:0] written [$];
    logic [31:0] addr;
    int kind;
    int lat;
    for (int t = 0; t < 20; t++) begin
        kind = int'($unsigned($random(seed)) % 3);
        if (kind == 0 || written.size() == 0) begin
            addr = $random(seed);
            if (addr[0]) begin
                addr[31:28] = 4'h0;   // About half the writes hit the low region.
            end
            data_access(1'b1, addr, random_line());
            written.push_back(addr);
        end else begin
            addr = written[$unsigned($random(seed)) % written.size()];
            if (kind == 1) begin
                data_access(1'b0, addr, '0);
            end else begin
                fetch_check(effective_addr(addr), lat);
            end
        end
    end
endtask

`endif

// File: verif/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;

    localparam int MEM_LINES  = mem_cfg_pkg::MEM_LINES_DEFAULT;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 6;
    localparam int WAIT_LIMIT = 50;   // Longest a single transaction may take, in cycles.

    logic         clk_i;
    logic         rst_ni;
    logic         i_req_i;
    logic [31:0]  i_addr_i;
    logic [127:0] i_rdata_o;
    logic         i_done_o;
    logic         d_req_i;
    logic         d_we_i;
    logic [31:0]  d_addr_i;
    logic [127:0] d_wdata_i;
    logic [127:0] d_rdata_o;
    logic         d_done_o;

    int errors;
    int checks;
    int seed;
    int cycle_cnt;
    logic [127:0] model_mem [int];   // Expected lines keyed by memory index.

    mem_subsystem_top #(.MEM_LINES(MEM_LINES)) dut0 (.*);

    `include "tb_tasks.svh"

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        seed      = 95010;
        errors    = 0;
        checks    = 0;
        rst_ni    = 1'b0;
        i_req_i   = 1'b0;
        i_addr_i  = '0;
        d_req_i   = 1'b0;
        d_we_i    = 1'b0;
        d_addr_i  = '0;
        d_wdata_i = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        test_idle_after_reset();
        test_data_write_read();
        test_low_region_remap();
        test_fetch_latency();
        test_simultaneous();
        test_random_mix();

        $display("Run complete: %0d checks, %0d errors.", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Each test gets a budget of 200 cycles.
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog expired before the tests finished.");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: compile.f
+incdir+verif
source/mem_cfg_pkg.sv
source/bus_pkg.sv
source/mem_port_if.sv
source/ifetch_port.sv
source/dmem_port.sv
source/mem_arbiter.sv
source/line_memory.sv
source/mem_subsystem_top.sv
verif/tb_mem_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_mem_subsystem -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_subsystem)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status."
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "Pass message not found in the simulation output."
exit 1
